// File: Bender.yml
package:
  name: rv_decoder

sources:
  - common/rv_decode_pkg.sv
  - decode/decode_table.sv
  - decode/imm_gen.sv
  - rtl/decode_queue.sv
  - rtl/rv_decoder_top.sv
  - target: test
    files:
      - tb/decode_assert.sv
      - tb/decode_checker.sv
      - tb/tb_rv_decoder.sv

// File: common/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    localparam int unsigned XLEN      = 32;
    localparam int unsigned INSTR_W   = 32;
    localparam int unsigned REG_IDX_W = 5;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_COND_BRANCH,
        PC_ALU_RES
    } pc_next_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        LT,
        LTU,
        GE,
        GEU,
        EQ,
        NEQ,
        PASS_B
    } alu_op_e;

    typedef enum logic {
        PORTA_RS1,
        PORTA_PC
    } porta_e;

    typedef enum logic {
        PORTB_RS2,
        PORTB_IMM
    } portb_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT
    } imm_fmt_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    typedef enum logic [1:0] {
        RF_ALU,
        RF_MEM,
        RF_PC_PLUS4
    } rf_src_e;

    typedef struct packed {
        pc_next_e               pc_next;
        logic                   branch;
        alu_op_e                alu_op;
        porta_e                 porta;
        portb_e                 portb;
        logic                   mem_read;
        logic                   mem_write;
        mem_size_e              mem_size;
        logic                   mem_unsigned;
        rf_src_e                rf_src;
        logic                   rf_write;
        logic                   illegal;
        logic [XLEN-1:0]        imm;
        logic [REG_IDX_W-1:0]   rd;
        logic [REG_IDX_W-1:0]   rs1;
        logic [REG_IDX_W-1:0]   rs2;
    } decode_word_t;

endpackage

`default_nettype wire

// File: decode/decode_table.sv
`timescale 1ns/1ps
`default_nettype none

module decode_table import rv_decode_pkg::*; (
    input  logic [INSTR_W-1:0] instr,
    output imm_fmt_e           imm_fmt,
    output decode_word_t       word
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Shared by register and immediate ALU forms
    // The alt bit picks SUB or SRA
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? SUB : ADD;
            3'b001:  alu_sel = SLL;
            3'b010:  alu_sel = LT;
            3'b011:  alu_sel = LTU;
            3'b100:  alu_sel = XOR;
            3'b101:  alu_sel = alt ? SRA : SRL;
            3'b110:  alu_sel = OR;
            default: alu_sel = AND;
        endcase
    endfunction

    always_comb begin
        word          = '0;
        word.pc_next  = PC_PLUS4;
        word.alu_op   = ADD;
        word.porta    = PORTA_RS1;
        word.portb    = PORTB_RS2;
        word.mem_size = SIZE_WORD;
        word.rf_src   = RF_ALU;
        imm_fmt       = IMM_I;

        case (opcode)
            OPC_OP: begin
                word.rf_write = 1'b1;
                word.alu_op   = alu_sel(funct3, funct7[5]);
                // Only ADD/SUB and SRL/SRA have an alternate funct7
                if (funct7 != 7'b0000000 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
                    word.illegal = 1'b1;
            end
            OPC_OP_IMM: begin
                word.portb    = PORTB_IMM;
                word.rf_write = 1'b1;
                word.alu_op   = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_fmt = IMM_SHAMT;
                    if (funct7 != 7'b0000000 && !(funct3 == 3'b101 && funct7 == 7'b0100000))
                        word.illegal = 1'b1;
                end
            end
            OPC_LOAD: begin
                word.portb        = PORTB_IMM;
                word.mem_read     = 1'b1;
                word.mem_unsigned = funct3[2];
                word.rf_src       = RF_MEM;
                word.rf_write     = 1'b1;
                case (funct3)
                    3'b000, 3'b100: word.mem_size = SIZE_BYTE;
                    3'b001, 3'b101: word.mem_size = SIZE_HALF;
                    3'b010:         word.mem_size = SIZE_WORD;
                    default:        word.illegal  = 1'b1;
                endcase
            end
            OPC_STORE: begin
                word.portb     = PORTB_IMM;
                word.mem_write = 1'b1;
                imm_fmt        = IMM_S;
                case (funct3)
                    3'b000:  word.mem_size = SIZE_BYTE;
                    3'b001:  word.mem_size = SIZE_HALF;
                    3'b010:  word.mem_size = SIZE_WORD;
                    default: word.illegal  = 1'b1;
                endcase
            end
            OPC_BRANCH: begin
                word.pc_next = PC_COND_BRANCH;
                word.branch  = 1'b1;
                imm_fmt      = IMM_B;
                case (funct3)
                    3'b000:  word.alu_op  = EQ;
                    3'b001:  word.alu_op  = NEQ;
                    3'b100:  word.alu_op  = LT;
                    3'b101:  word.alu_op  = GE;
                    3'b110:  word.alu_op  = LTU;
                    3'b111:  word.alu_op  = GEU;
                    default: word.illegal = 1'b1;
                endcase
            end
            OPC_JAL: begin
                word.pc_next  = PC_ALU_RES;
                word.branch   = 1'b1;
                word.porta    = PORTA_PC;
                word.portb    = PORTB_IMM;
                word.rf_src   = RF_PC_PLUS4;
                word.rf_write = 1'b1;
                imm_fmt       = IMM_J;
            end
            OPC_JALR: begin
                word.pc_next  = PC_ALU_RES;
                word.portb    = PORTB_IMM;
                word.rf_src   = RF_PC_PLUS4;
                word.rf_write = 1'b1;
                word.illegal  = (funct3 != 3'b000);
            end
            OPC_LUI: begin
                word.alu_op   = PASS_B;
                word.portb    = PORTB_IMM;
                word.rf_write = 1'b1;
                imm_fmt       = IMM_U;
            end
            OPC_AUIPC: begin
                word.porta    = PORTA_PC;
                word.portb    = PORTB_IMM;
                word.rf_write = 1'b1;
                imm_fmt       = IMM_U;
            end
            // FENCE, SYSTEM and unknown opcodes
            default: word.illegal = 1'b1;
        endcase

        // Illegal words fall back to a harmless sequential no-op
        if (word.illegal) begin
            word          = '0;
            word.illegal  = 1'b1;
            word.pc_next  = PC_PLUS4;
            word.alu_op   = ADD;
            word.porta    = PORTA_RS1;
            word.portb    = PORTB_RS2;
            word.mem_size = SIZE_WORD;
            word.rf_src   = RF_ALU;
            imm_fmt       = IMM_I;
        end

        word.rd  = instr[11:7];
        word.rs1 = instr[19:15];
        word.rs2 = instr[24:20];
    end

endmodule

`default_nettype wire

// File: decode/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen import rv_decode_pkg::*; (
    input  logic [INSTR_W-1:0] instr,
    input  imm_fmt_e           imm_fmt,
    output logic [XLEN-1:0]    imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_fmt)
            IMM_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // Bit 0 is always zero for branch offsets
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            IMM_SHAMT: begin
                imm = {27'b0, instr[24:20]};
            end
            default: begin
                imm = {{20{sign}}, instr[31:20]};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: project.f
common/rv_decode_pkg.sv
decode/decode_table.sv
decode/imm_gen.sv
rtl/decode_queue.sv
rtl/rv_decoder_top.sv
tb/decode_assert.sv
tb/decode_checker.sv
tb/tb_rv_decoder.sv

// File: rtl/decode_queue.sv
`timescale 1ns/1ps
`default_nettype none

module decode_queue import rv_decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  decode_word_t in_word,
    output logic         in_credit,
    input  logic         out_credit,
    output logic         out_valid,
    output decode_word_t out_word
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    decode_word_t     mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credit_cnt;
    logic             pop;

    // Depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Send the head only when the consumer has room for it
    assign pop = (count != '0) && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (in_valid)
            mem[wr_ptr] <= in_word;
        if (pop)
            out_word <= mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CRD_W'(OUT_CREDITS);
            out_valid  <= 1'b0;
            in_credit  <= 1'b0;
        end else begin
            if (in_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            count      <= count + CNT_W'(in_valid) - CNT_W'(pop);
            credit_cnt <= credit_cnt + CRD_W'(out_credit) - CRD_W'(pop);
            out_valid  <= pop;
            // Slot freed once the word has left
            in_credit  <= out_valid;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_top import rv_decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic [INSTR_W-1:0]   instr,
    output logic                 in_credit,
    input  logic                 out_credit,
    output logic                 out_valid,
    output pc_next_e             pc_next_sel,
    output logic                 branch,
    output alu_op_e              alu_op_sel,
    output porta_e               alu_porta_sel,
    output portb_e               alu_portb_sel,
    output logic                 mem_read,
    output logic                 mem_write,
    output mem_size_e            mem_size,
    output logic                 mem_unsigned,
    output rf_src_e              rf_src_sel,
    output logic                 rf_write,
    output logic                 illegal,
    output logic [XLEN-1:0]      imm,
    output logic [REG_IDX_W-1:0] rd,
    output logic [REG_IDX_W-1:0] rs1,
    output logic [REG_IDX_W-1:0] rs2
);

    imm_fmt_e        imm_fmt;
    logic [XLEN-1:0] dec_imm;
    decode_word_t    table_word;
    decode_word_t    queue_in_word;
    decode_word_t    queue_out_word;

    decode_table decode_table_i (
        .instr   (instr),
        .imm_fmt (imm_fmt),
        .word    (table_word)
    );

    imm_gen imm_gen_i (
        .instr   (instr),
        .imm_fmt (imm_fmt),
        .imm     (dec_imm)
    );

    always_comb begin
        queue_in_word     = table_word;
        queue_in_word.imm = dec_imm;
    end

    decode_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) decode_queue_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_word    (queue_in_word),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_word   (queue_out_word)
    );

    assign pc_next_sel   = queue_out_word.pc_next;
    assign branch        = queue_out_word.branch;
    assign alu_op_sel    = queue_out_word.alu_op;
    assign alu_porta_sel = queue_out_word.porta;
    assign alu_portb_sel = queue_out_word.portb;
    assign mem_read      = queue_out_word.mem_read;
    assign mem_write     = queue_out_word.mem_write;
    assign mem_size      = queue_out_word.mem_size;
    assign mem_unsigned  = queue_out_word.mem_unsigned;
    assign rf_src_sel    = queue_out_word.rf_src;
    assign rf_write      = queue_out_word.rf_write;
    assign illegal       = queue_out_word.illegal;
    assign imm           = queue_out_word.imm;
    assign rd            = queue_out_word.rd;
    assign rs1           = queue_out_word.rs1;
    assign rs2           = queue_out_word.rs2;

endmodule

`default_nettype wire

// File: tb/decode_assert.sv
`timescale 1ns/1ps
`default_nettype none

module decode_assert import rv_decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input logic                               clk,
    input logic                               rst,
    input logic                               in_valid,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0]   count,
    input logic [$clog2(OUT_CREDITS+1)-1:0]   credit_cnt,
    input logic                               out_valid,
    input logic                               in_credit,
    input decode_word_t                       out_word
);

    int unsigned fail_count = 0;

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> count < QUEUE_DEPTH)
        else begin
            $error("push into a full decode queue");
            fail_count++;
        end

    // Zero credits this cycle means nothing is popped, so nothing shows next cycle
    no_send_without_credit: assert property (@(posedge clk) disable iff (rst)
        (credit_cnt == '0) |=> !out_valid)
        else begin
            $error("out_valid raised with no downstream credit");
            fail_count++;
        end

    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !(out_word.mem_read && out_word.mem_write))
        else begin
            $error("decoded word has both mem_read and mem_write set");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!out_valid && !in_credit))
        else begin
            $error("out_valid or in_credit high in the cycle after reset");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: tb/decode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_checker import rv_decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic [INSTR_W-1:0]   instr,
    input  logic                 in_credit,
    input  logic                 out_credit,
    input  logic                 out_valid,
    input  pc_next_e             pc_next_sel,
    input  logic                 branch,
    input  alu_op_e              alu_op_sel,
    input  porta_e               alu_porta_sel,
    input  portb_e               alu_portb_sel,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  mem_size_e            mem_size,
    input  logic                 mem_unsigned,
    input  rf_src_e              rf_src_sel,
    input  logic                 rf_write,
    input  logic                 illegal,
    input  logic [XLEN-1:0]      imm,
    input  logic [REG_IDX_W-1:0] rd,
    input  logic [REG_IDX_W-1:0] rs1,
    input  logic [REG_IDX_W-1:0] rs2,
    output int                   error_count
);

    decode_word_t exp_q[$];
    int           errors = 0;
    int           in_count = 0;
    int           out_count = 0;
    int           in_credit_count = 0;
    int           out_credit_count = 0;
    logic         prev_out_valid = 1'b0;

    assign error_count = errors;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    arith_op = alt ? SUB : ADD;
            3'd1:    arith_op = SLL;
            3'd2:    arith_op = LT;
            3'd3:    arith_op = LTU;
            3'd4:    arith_op = XOR;
            3'd5:    arith_op = alt ? SRA : SRL;
            3'd6:    arith_op = OR;
            default: arith_op = AND;
        endcase
    endfunction

    function automatic mem_size_e access_size(input logic [1:0] low_f3);
        case (low_f3)
            2'd0:    access_size = SIZE_BYTE;
            2'd1:    access_size = SIZE_HALF;
            default: access_size = SIZE_WORD;
        endcase
    endfunction

    function automatic decode_word_t model_decode(input logic [31:0] ins);
        decode_word_t       w;
        logic signed [31:0] simm;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic               legal;
        f3 = ins[14:12];
        f7 = ins[31:25];
        legal = 1'b1;
        w = '0;
        w.mem_size = SIZE_WORD;
        simm = $signed(ins[31:20]);
        case (ins[6:0])
            OPC_OP: begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                w.alu_op = arith_op(f3, f7 == 7'h20);
                w.rf_write = 1'b1;
            end
            OPC_OP_IMM: begin
                w.portb = PORTB_IMM;
                w.rf_write = 1'b1;
                w.alu_op = arith_op(f3, f3 == 3'd5 && f7 == 7'h20);
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    simm = {27'b0, ins[24:20]};
                    legal = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
                end
            end
            OPC_LOAD: begin
                legal = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
                w.portb = PORTB_IMM;
                w.mem_read = 1'b1;
                w.mem_size = access_size(f3[1:0]);
                w.mem_unsigned = (f3 == 3'd4) || (f3 == 3'd5);
                w.rf_src = RF_MEM;
                w.rf_write = 1'b1;
            end
            OPC_STORE: begin
                legal = (f3 < 3'd3);
                w.portb = PORTB_IMM;
                w.mem_write = 1'b1;
                w.mem_size = access_size(f3[1:0]);
                simm = $signed({ins[31:25], ins[11:7]});
            end
            OPC_BRANCH: begin
                w.pc_next = PC_COND_BRANCH;
                w.branch = 1'b1;
                simm = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
                case (f3)
                    3'd0:    w.alu_op = EQ;
                    3'd1:    w.alu_op = NEQ;
                    3'd4:    w.alu_op = LT;
                    3'd5:    w.alu_op = GE;
                    3'd6:    w.alu_op = LTU;
                    3'd7:    w.alu_op = GEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                w.pc_next = PC_ALU_RES;
                w.branch = 1'b1;
                w.porta = PORTA_PC;
                w.portb = PORTB_IMM;
                w.rf_src = RF_PC_PLUS4;
                w.rf_write = 1'b1;
                simm = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
            end
            OPC_JALR: begin
                legal = (f3 == 3'd0);
                w.pc_next = PC_ALU_RES;
                w.portb = PORTB_IMM;
                w.rf_src = RF_PC_PLUS4;
                w.rf_write = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                w.alu_op = (ins[6:0] == OPC_LUI) ? PASS_B : ADD;
                w.porta = (ins[6:0] == OPC_LUI) ? PORTA_RS1 : PORTA_PC;
                w.portb = PORTB_IMM;
                w.rf_write = 1'b1;
                simm = {ins[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            w = '0;
            w.illegal = 1'b1;
            w.mem_size = SIZE_WORD;
            simm = $signed(ins[31:20]);
        end
        w.imm = simm;
        w.rd = ins[11:7];
        w.rs1 = ins[19:15];
        w.rs2 = ins[24:20];
        return w;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_output(input decode_word_t e);
        compare_field("pc_next_sel", e.pc_next, pc_next_sel);
        compare_field("branch", e.branch, branch);
        compare_field("alu_op_sel", e.alu_op, alu_op_sel);
        compare_field("alu_porta_sel", e.porta, alu_porta_sel);
        compare_field("alu_portb_sel", e.portb, alu_portb_sel);
        compare_field("mem_read", e.mem_read, mem_read);
        compare_field("mem_write", e.mem_write, mem_write);
        compare_field("mem_size", e.mem_size, mem_size);
        compare_field("mem_unsigned", e.mem_unsigned, mem_unsigned);
        compare_field("rf_src_sel", e.rf_src, rf_src_sel);
        compare_field("rf_write", e.rf_write, rf_write);
        compare_field("illegal", e.illegal, illegal);
        compare_field("imm", e.imm, imm);
        compare_field("rd", e.rd, rd);
        compare_field("rs1", e.rs1, rs1);
        compare_field("rs2", e.rs2, rs2);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            // Each out_valid returns its upstream credit one cycle later
            compare_field("in_credit", prev_out_valid, in_credit);
            if (out_credit)
                out_credit_count++;
            if (in_credit)
                in_credit_count++;
            if (out_valid) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("At %0t out_valid came with no instruction outstanding", $time);
                end else begin
                    check_output(exp_q.pop_front());
                end
                if (out_count > OUT_CREDITS + out_credit_count) begin
                    errors++;
                    $display("At %0t more words were sent than downstream credits allow",
                             $time);
                end
            end
            if (in_valid) begin
                in_count++;
                exp_q.push_back(model_decode(instr));
                if (QUEUE_DEPTH + in_credit_count - in_count < 0) begin
                    errors++;
                    $display("At %0t the source sent without an upstream credit", $time);
                end
            end
        end
        prev_out_valid = rst ? 1'b0 : out_valid;
    end

    task automatic final_check(input int sent_count);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d decoded words never left the queue", exp_q.size());
        end
        if (in_count != sent_count) begin
            errors++;
            $display("DUT accepted %0d instructions but the source sent %0d",
                     in_count, sent_count);
        end
        if (out_count != in_count) begin
            errors++;
            $display("%0d words left the queue for %0d accepted", out_count, in_count);
        end
        if (in_credit_count != out_count) begin
            errors++;
            $display("%0d in_credit pulses for %0d words sent", in_credit_count, out_count);
        end
    endtask

endmodule

`default_nettype wire

// File: tb/tb_rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decoder import rv_decode_pkg::*; ();

    localparam int QUEUE_DEPTH    = 4;
    localparam int OUT_CREDITS    = 2;
    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 10 + 200;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic [INSTR_W-1:0]   instr;
    logic                 in_credit;
    logic                 out_credit;
    logic                 out_valid;
    pc_next_e             pc_next_sel;
    logic                 branch;
    alu_op_e              alu_op_sel;
    porta_e               alu_porta_sel;
    portb_e               alu_portb_sel;
    logic                 mem_read;
    logic                 mem_write;
    mem_size_e            mem_size;
    logic                 mem_unsigned;
    rf_src_e              rf_src_sel;
    logic                 rf_write;
    logic                 illegal;
    logic [XLEN-1:0]      imm;
    logic [REG_IDX_W-1:0] rd;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    int                   checker_errors;

    integer seed = 3;
    int     credits;
    int     owed;
    int     sent;
    int     received;
    int     hold;
    int     src_errors;
    int     total_errors;
    int     cycle_count = 0;

    rv_decoder_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) rv_decoder_top_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .instr(instr),
        .in_credit(in_credit), .out_credit(out_credit), .out_valid(out_valid),
        .pc_next_sel(pc_next_sel), .branch(branch), .alu_op_sel(alu_op_sel),
        .alu_porta_sel(alu_porta_sel), .alu_portb_sel(alu_portb_sel),
        .mem_read(mem_read), .mem_write(mem_write), .mem_size(mem_size),
        .mem_unsigned(mem_unsigned), .rf_src_sel(rf_src_sel), .rf_write(rf_write),
        .illegal(illegal), .imm(imm), .rd(rd), .rs1(rs1), .rs2(rs2)
    );

    decode_checker #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) decode_checker_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .instr(instr),
        .in_credit(in_credit), .out_credit(out_credit), .out_valid(out_valid),
        .pc_next_sel(pc_next_sel), .branch(branch), .alu_op_sel(alu_op_sel),
        .alu_porta_sel(alu_porta_sel), .alu_portb_sel(alu_portb_sel),
        .mem_read(mem_read), .mem_write(mem_write), .mem_size(mem_size),
        .mem_unsigned(mem_unsigned), .rf_src_sel(rf_src_sel), .rf_write(rf_write),
        .illegal(illegal), .imm(imm), .rd(rd), .rs1(rs1), .rs2(rs2),
        .error_count(checker_errors)
    );

    bind decode_queue decode_assert #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) decode_assert_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .count(count),
        .credit_cnt(credit_cnt), .out_valid(out_valid), .in_credit(in_credit),
        .out_word(out_word)
    );

    always #5 clk = ~clk;

    // Legal RV32I encodings most of the time, otherwise junk or dropped encodings
    task automatic make_instr(output logic [31:0] ins);
        logic [31:0] r;
        logic [2:0]  f3;
        int unsigned pick;
        r = $random(seed);
        f3 = r[14:12];
        ins = r;
        pick = $unsigned($random(seed)) % 100;
        if (pick < 70) begin
            case ($unsigned($random(seed)) % 9)
                0: begin
                    ins[6:0] = OPC_OP;
                    ins[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
                end
                1: begin
                    ins[6:0] = OPC_OP_IMM;
                    if (f3 == 3'd1 || f3 == 3'd5)
                        ins[31:25] = (f3 == 3'd5 && r[30]) ? 7'h20 : 7'h00;
                end
                2: begin
                    ins[6:0] = OPC_LOAD;
                    if (f3 == 3'd3 || f3 >= 3'd6)
                        ins[14:12] = 3'd2;
                end
                3: begin
                    ins[6:0] = OPC_STORE;
                    ins[14:12] = (r[13:12] == 2'd3) ? 3'd2 : {1'b0, r[13:12]};
                end
                4: begin
                    ins[6:0] = OPC_BRANCH;
                    if (f3 == 3'd2 || f3 == 3'd3)
                        ins[14:12] = {1'b1, f3[1:0]};
                end
                5: ins[6:0] = OPC_JAL;
                6: begin
                    ins[6:0] = OPC_JALR;
                    ins[14:12] = 3'd0;
                end
                7: ins[6:0] = OPC_LUI;
                default: ins[6:0] = OPC_AUIPC;
            endcase
        end else begin
            case (pick % 4)
                0: ins = r;
                1: begin
                    // M extension
                    ins[6:0] = OPC_OP;
                    ins[31:25] = 7'b0000001;
                end
                2: ins[6:0] = 7'b0001111;
                default: ins = r[0] ? 32'h0010_0073 : 32'h0000_0073;
            endcase
        end
    endtask

    task automatic drive_source();
        logic [31:0] word;
        in_valid = 1'b0;
        if (sent < NUM_INSTR && credits > 0 && ($unsigned($random(seed)) % 4) != 0) begin
            make_instr(word);
            instr = word;
            in_valid = 1'b1;
            credits--;
            sent++;
        end
    endtask

    // Returns credits only for words already taken and sometimes stalls for long stretches
    task automatic drive_consumer();
        out_credit = 1'b0;
        if (hold > 0) begin
            hold--;
        end else if (($unsigned($random(seed)) % 50) == 0) begin
            hold = 20 + $unsigned($random(seed)) % 40;
        end else if (owed > 0 && ($unsigned($random(seed)) % 3) != 0) begin
            out_credit = 1'b1;
            owed--;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        instr = '0;
        out_credit = 1'b0;
        credits = QUEUE_DEPTH;
        owed = 0;
        sent = 0;
        received = 0;
        hold = 0;
        src_errors = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        while (received < NUM_INSTR) begin
            @(posedge clk);
            if (in_credit)
                credits++;
            if (out_valid) begin
                owed++;
                received++;
            end
            #1;
            drive_consumer();
            drive_source();
        end
        // Wait for the last in_credit pulses to come back
        while (credits < QUEUE_DEPTH) begin
            @(posedge clk);
            if (in_credit)
                credits++;
            #1;
            out_credit = 1'b0;
            in_valid = 1'b0;
        end
        if (credits != QUEUE_DEPTH) begin
            src_errors++;
            $display("Source holds %0d credits after draining, expected %0d",
                     credits, QUEUE_DEPTH);
        end
        decode_checker_i.final_check(sent);
        total_errors = checker_errors + src_errors +
                       rv_decoder_top_i.decode_queue_i.decode_assert_i.fail_count;
        $display("Errors: %0d (words sent %0d, received %0d)", total_errors, sent, received);
        if (total_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
